// ==== cnn_top.f ====
source/cnn_pkg.sv
source/layer_sequencer.sv
source/data_loader.sv
source/buffer_arbiter.sv
source/feature_buffer.sv
source/layer_engine.sv
source/cnn_top.sv
verification/cnn_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cnn testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f cnn_top.f --top-module cnn_tb -o cnn_sim

./obj_dir/cnn_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== source/buffer_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_arbiter import cnn_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  buf_req_t          load_req,
	input  buf_req_t          eng_req,
	input  logic [DATA_W-1:0] rdata_in,   // from buffer
	output logic              load_grant,
	output logic              eng_grant,
	output buf_req_t          mem_req,    // to buffer
	output logic [DATA_W-1:0] rdata,
	output logic              load_rvalid,
	output logic              eng_rvalid
);

	logic rd_load;  // read in flight belongs to loader
	logic rd_eng;

	////////////////////////////////////////
	// fixed priority, loader wins
	assign load_grant = load_req.req;
	assign eng_grant  = eng_req.req && !load_req.req;

	assign mem_req = load_req.req ? load_req : eng_req; // idle engine req has req low

	// remember who read, data shows up next cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_load <= 1'b0;
			rd_eng  <= 1'b0;
		end else begin
			rd_load <= load_grant && !load_req.we;
			rd_eng  <= eng_grant && !eng_req.we;
		end
	end

	assign load_rvalid = rd_load;
	assign eng_rvalid  = rd_eng;
	assign rdata       = rdata_in;  // shared, qualified by rvalid

endmodule

`default_nettype wire

// ==== source/cnn_pkg.sv ====
`default_nettype none

package cnn_pkg;

	////////////////////////////////////////
	// network steps, in walk order
	typedef enum logic [2:0] {
		lt_load,   // stream map and weights in
		lt_conv,   // 3-tap conv + relu
		lt_pool,   // max over pairs
		lt_fc,     // dot product, one result
		lt_finish  // hold done
	} layer_type_e;

	////////////////////////////////////////
	// sizes
	localparam int MAP_LEN    = 16;           // must be even
	localparam int POOL_LEN   = MAP_LEN / 2;  // also fc weight count
	localparam int CW_LEN     = 3;            // conv taps
	localparam int LOAD_WORDS = MAP_LEN + CW_LEN + POOL_LEN; // 27
	localparam int ADDR_W     = 6;            // 64 word buffer
	localparam int WORD_W     = 16;           // write bus width

	////////////////////////////////////////
	// buffer address map
	localparam logic [ADDR_W-1:0] FM_BASE   = 6'd0;  // input map
	localparam logic [ADDR_W-1:0] CONV_BASE = 6'd16; // conv out
	localparam logic [ADDR_W-1:0] POOL_BASE = 6'd32; // pool out
	localparam logic [ADDR_W-1:0] CW_BASE   = 6'd40; // conv weights
	localparam logic [ADDR_W-1:0] FW_BASE   = 6'd48; // fc weights

	// one buffer access, held until granted
	typedef struct packed {
		logic              req;
		logic              we;    // 1 write, 0 read
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata; // sign extended word
	} buf_req_t;

endpackage

`default_nettype wire

// ==== source/cnn_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_top import cnn_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               load_valid,
	input  logic [DATA_W-1:0]  load_data,
	output logic [2:0]         layer_num,
	output layer_type_e        layer_type,
	output logic               done,
	output logic signed [31:0] result,
	output logic               result_valid
);

	buf_req_t          load_req, eng_req, mem_req;
	logic              load_grant, eng_grant;
	logic              load_done, layer_done;
	logic              layer_ready;
	logic [DATA_W-1:0] buf_rdata, rdata;
	logic              eng_rvalid;

	assign layer_ready = load_done | layer_done;  // either peer ends a step

	layer_sequencer seq0 (
		.clk(clk), .rst_n(rst_n), .start(start), .layer_ready(layer_ready),
		.layer_num(layer_num), .layer_type(layer_type), .done(done)
	);

	data_loader #(.DATA_W(DATA_W)) ldr0 (
		.clk(clk), .rst_n(rst_n), .start(start), .layer_type(layer_type),
		.load_valid(load_valid), .load_data(load_data), .grant(load_grant),
		.req(load_req), .load_done(load_done)
	);

	layer_engine #(.DATA_W(DATA_W)) eng0 (
		.clk(clk), .rst_n(rst_n), .layer_type(layer_type), .grant(eng_grant),
		.rdata(rdata), .rvalid(eng_rvalid), .req(eng_req), .layer_done(layer_done),
		.result(result), .result_valid(result_valid)
	);

	// loader only writes, its rvalid stays unused
	buffer_arbiter #(.DATA_W(DATA_W)) arb0 (
		.clk(clk), .rst_n(rst_n), .load_req(load_req), .eng_req(eng_req),
		.rdata_in(buf_rdata), .load_grant(load_grant), .eng_grant(eng_grant),
		.mem_req(mem_req), .rdata(rdata), .load_rvalid(), .eng_rvalid(eng_rvalid)
	);

	feature_buffer #(.DATA_W(DATA_W)) buf0 (
		.clk(clk), .req(mem_req), .rdata(buf_rdata)
	);

endmodule

`default_nettype wire

// ==== source/data_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_loader import cnn_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  layer_type_e       layer_type,
	input  logic              load_valid,  // one word per strobe
	input  logic [DATA_W-1:0] load_data,
	input  logic              grant,
	output buf_req_t          req,
	output logic              load_done    // pulse after last write
);

	localparam int CNT_W = $clog2(LOAD_WORDS + 1);

	logic [CNT_W-1:0]  acc_cnt;   // words taken from the stream
	logic [CNT_W-1:0]  iss_cnt;   // words put on the bus
	logic              req_vld;
	logic [ADDR_W-1:0] req_addr;
	logic [DATA_W-1:0] req_data;
	logic              skid_vld;  // one word parked behind a stalled write
	logic [DATA_W-1:0] skid_data;
	logic              take;
	logic              slot_free;

	// stream order: map, conv weights, fc weights
	function automatic logic [ADDR_W-1:0] word_addr(input logic [CNT_W-1:0] k);
		if (k < MAP_LEN)
			return FM_BASE + ADDR_W'(k);
		else if (k < MAP_LEN + CW_LEN)
			return CW_BASE + ADDR_W'(k - MAP_LEN);
		else
			return FW_BASE + ADDR_W'(k - MAP_LEN - CW_LEN);
	endfunction

	assign take      = load_valid && (acc_cnt < LOAD_WORDS) && (layer_type == lt_load);
	assign slot_free = !req_vld || grant;  // current write leaves this cycle

	assign req = '{req: req_vld, we: 1'b1, addr: req_addr, wdata: WORD_W'(signed'(req_data))};

	always_ff @(posedge clk) begin
		if (!rst_n || !start) begin
			acc_cnt   <= '0;
			iss_cnt   <= '0;
			req_vld   <= 1'b0;
			skid_vld  <= 1'b0;
			load_done <= 1'b0;
		end else begin
			load_done <= req_vld && grant && (iss_cnt == LOAD_WORDS); // last one out
			if (take)
				acc_cnt <= acc_cnt + 1'b1;
			if (slot_free) begin
				if (skid_vld) begin                // parked word goes first
					req_vld   <= 1'b1;
					req_data  <= skid_data;
					req_addr  <= word_addr(iss_cnt);
					iss_cnt   <= iss_cnt + 1'b1;
					skid_vld  <= take;
					skid_data <= load_data;
				end else if (take) begin
					req_vld  <= 1'b1;
					req_data <= load_data;
					req_addr <= word_addr(iss_cnt);
					iss_cnt  <= iss_cnt + 1'b1;
				end else begin
					req_vld <= 1'b0;
				end
			end else if (take) begin
				skid_vld  <= 1'b1;  // write still waiting
				skid_data <= load_data;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/feature_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module feature_buffer import cnn_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  buf_req_t          req,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] mem [2**ADDR_W];  // map, layer outputs, weights

	// single port, one access per cycle
	always_ff @(posedge clk) begin
		if (req.req) begin
			if (req.we)
				mem[req.addr] <= req.wdata[DATA_W-1:0];  // keep low bits
			else
				rdata <= mem[req.addr];  // one cycle latency
		end
	end

endmodule

`default_nettype wire

// ==== source/layer_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module layer_engine import cnn_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  layer_type_e        layer_type,
	input  logic               grant,
	input  logic [DATA_W-1:0]  rdata,
	input  logic               rvalid,
	output buf_req_t           req,
	output logic               layer_done,   // pulse per compute step
	output logic signed [31:0] result,
	output logic               result_valid  // one cycle before layer_done
);

	localparam int IDX_W = $clog2(MAP_LEN);

	typedef enum logic [2:0] {st_idle, st_rd, st_wait, st_wr, st_done} state_e;

	state_e                    state;
	layer_type_e               prev_type;  // entry detect
	logic                      wphase;     // conv weight preload
	logic [IDX_W-1:0]          idx;        // output index
	logic [1:0]                tap;
	logic signed [31:0]        acc;
	logic signed [31:0]        acc_nx;
	logic signed [DATA_W-1:0]  w [CW_LEN];
	logic signed [DATA_W-1:0]  hold;       // fc weight of current pair
	logic signed [DATA_W-1:0]  x;
	logic                      pad, last_tap, last_idx, step;
	logic [ADDR_W-1:0]         rd_addr, wr_addr;
	logic [DATA_W-1:0]         wr_val;

	assign x = rdata;

	// zero padding, edge taps skip their read
	assign pad = !wphase && (layer_type == lt_conv) &&
		((idx == '0 && tap == 2'd0) || (idx == IDX_W'(MAP_LEN - 1) && tap == 2'd2));
	assign last_tap = (wphase || layer_type == lt_conv) ? (tap == 2'd2) : (tap == 2'd1);
	assign last_idx = (layer_type == lt_conv) ? (idx == IDX_W'(MAP_LEN - 1)) :
		(idx == IDX_W'(POOL_LEN - 1));
	assign step = (state == st_rd && pad) || (state == st_wait && rvalid);

	////////////////////////////////////////
	// addresses per step
	always_comb begin
		if (wphase)
			rd_addr = CW_BASE + ADDR_W'(tap);
		else case (layer_type)
			lt_conv: rd_addr = FM_BASE + ADDR_W'(idx) + ADDR_W'(tap) - ADDR_W'(1); // x[i-1+tap]
			lt_pool: rd_addr = CONV_BASE + ADDR_W'({idx, 1'b0}) + ADDR_W'(tap);
			default: rd_addr = tap[0] ? POOL_BASE + ADDR_W'(idx) : FW_BASE + ADDR_W'(idx);
		endcase
	end

	assign wr_addr = (layer_type == lt_conv) ? CONV_BASE + ADDR_W'(idx) : POOL_BASE + ADDR_W'(idx);
	assign wr_val  = (layer_type == lt_conv && acc[31]) ? '0 : acc[DATA_W-1:0]; // relu on conv

	assign req = '{req: (state == st_rd && !pad) || state == st_wr, we: state == st_wr,
		addr: (state == st_wr) ? wr_addr : rd_addr, wdata: WORD_W'(signed'(wr_val))};

	// mac or compare on returned word
	always_comb begin
		acc_nx = acc;
		if (state == st_wait && rvalid && !wphase) begin
			case (layer_type)
				lt_conv: acc_nx = acc + w[tap] * x;
				lt_pool: if (tap == 2'd0 || x > acc) acc_nx = x;
				lt_fc:   if (tap == 2'd1) acc_nx = acc + hold * x;
				default: acc_nx = acc;
			endcase
		end
	end

	////////////////////////////////////////
	// step FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= st_idle;
			prev_type    <= lt_load;
			layer_done   <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			prev_type    <= layer_type;
			layer_done   <= 1'b0;
			result_valid <= 1'b0;
			case (state)
				st_idle: if (layer_type != prev_type &&
					(layer_type == lt_conv || layer_type == lt_pool || layer_type == lt_fc)) begin
					state  <= st_rd;  // new step
					wphase <= (layer_type == lt_conv);
					idx    <= '0;
					tap    <= 2'd0;
					acc    <= '0;
				end
				st_rd, st_wait: if (step) begin
					if (wphase)
						w[tap] <= x;
					if (layer_type == lt_fc && tap == 2'd0)
						hold <= x;
					acc <= acc_nx;
					if (!last_tap) begin
						tap   <= tap + 2'd1;
						state <= st_rd;
					end else if (wphase) begin
						wphase <= 1'b0;  // weights in, start outputs
						tap    <= 2'd0;
						state  <= st_rd;
					end else if (layer_type != lt_fc) begin
						state <= st_wr;
					end else if (last_idx) begin
						result       <= acc_nx;
						result_valid <= 1'b1;
						state        <= st_done;
					end else begin
						idx   <= idx + 1'b1;  // fc keeps summing
						tap   <= 2'd0;
						state <= st_rd;
					end
				end else if (state == st_rd && grant) begin
					state <= st_wait;
				end
				st_wr: if (grant) begin
					if (last_idx) begin
						state <= st_done;
					end else begin
						idx   <= idx + 1'b1;
						tap   <= 2'd0;
						acc   <= '0;
						state <= st_rd;
					end
				end
				st_done: begin
					layer_done <= 1'b1;
					state      <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/layer_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module layer_sequencer import cnn_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,       // level, run while high
	input  logic        layer_ready, // step finished
	output logic [2:0]  layer_num,
	output layer_type_e layer_type,
	output logic        done
);

	logic ready_d;  // last cycle's ready, for edge detect
	logic advance;

	// fixed network: load, conv, pool, fc, finish
	function automatic layer_type_e type_of(input logic [2:0] n);
		case (n)
			3'd0: return lt_load;
			3'd1: return lt_conv;
			3'd2: return lt_pool;
			3'd3: return lt_fc;
			default: return lt_finish;
		endcase
	endfunction

	// count a held ready only once
	assign advance = start && layer_ready && !ready_d && (layer_type != lt_finish);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ready_d <= 1'b0;
		end else begin
			ready_d <= layer_ready;
		end
	end

	////////////////////////////////////////
	// layer count and type
	always_ff @(posedge clk) begin
		if (!rst_n || !start) begin
			layer_num  <= 3'd0;  // start low re-arms the walk
			layer_type <= lt_load;
			done       <= 1'b0;
		end else if (advance) begin
			layer_num  <= layer_num + 3'd1;
			layer_type <= type_of(layer_num + 3'd1);
			done       <= (type_of(layer_num + 3'd1) == lt_finish); // sticks till start drops
		end
	end

endmodule

`default_nettype wire

// ==== verification/cnn_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cnn_tb import cnn_pkg::*; ();

	localparam int DATA_W  = 16;
	localparam int CLK_NS  = 4;
	localparam int MAX_GAP = 4;  // idle cycles after a strobe, gap mode
	// worst case per run: gapped load, weight preload, conv, pool, fc, slack
	localparam int RUN_CYC = LOAD_WORDS * (MAX_GAP + 1) + 2 * CW_LEN + MAP_LEN * 7 +
		POOL_LEN * 5 + POOL_LEN * 4 + 64;
	localparam int WATCHDOG_NS = (4 * RUN_CYC + 24 + 16 + 200) * CLK_NS;

	logic               clk = 1'b0;
	logic               rst_n = 1'b0;
	logic               start = 1'b0;
	logic               load_valid = 1'b0;
	logic [DATA_W-1:0]  load_data = '0;
	logic [2:0]         layer_num;
	layer_type_e        layer_type;
	logic               done;
	logic signed [31:0] result;
	logic               result_valid;

	logic [31:0] lfsr = 32'he3ee3f8f;
	int          words [LOAD_WORDS];  // map, conv weights, fc weights
	int          exp_result;
	int          got_result;
	int          rv_cnt;              // result pulses this run
	logic [4:0]  seen;                // layer types visited this run
	logic [2:0]  prev_num = 3'd0;
	int          err_cnt = 0;
	int          tests = 0;
	int          failed = 0;
	layer_type_e walk_order [5] = '{lt_load, lt_conv, lt_pool, lt_fc, lt_finish};

	always #(CLK_NS / 2) clk = ~clk;

	cnn_top #(.DATA_W(DATA_W)) dut0 (
		.clk(clk), .rst_n(rst_n), .start(start), .load_valid(load_valid),
		.load_data(load_data), .layer_num(layer_num), .layer_type(layer_type),
		.done(done), .result(result), .result_valid(result_valid)
	);

	////////////////////////////////////////
	// random bits, galois lfsr x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);  // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic fill_random();
		logic [31:0] b;
		for (int k = 0; k < LOAD_WORDS; k++) begin
			rand_bits(4, b);
			words[k] = int'($signed(b[3:0]));  // -8..7, sums stay small
		end
	endtask

	// positive map 5..7, taps push every interior output below zero
	task automatic fill_padding();
		logic [31:0] b;
		for (int k = 0; k < MAP_LEN; k++) begin
			rand_bits(2, b);
			words[k] = (b[1:0] == 2'd3) ? 7 : 5 + int'(b[1:0]);
		end
		words[0]         = 5;   // left edge: -5*5 + 6*7 > 0 once x[-1] is padded
		words[1]         = 7;
		words[MAP_LEN]   = -7;  // tap on x[i-1]
		words[MAP_LEN+1] = -5;
		words[MAP_LEN+2] = 6;   // tap on x[i+1]
		for (int j = 0; j < POOL_LEN; j++) begin
			rand_bits(3, b);
			words[MAP_LEN+CW_LEN+j] = 1 + int'(b[2:0]);
		end
	endtask

	////////////////////////////////////////
	// reference model of the network
	function automatic int model_result();
		int c [MAP_LEN];
		int s;
		int sum;
		int p;
		s = 0;
		for (int i = 0; i < MAP_LEN; i++) begin
			sum = words[MAP_LEN+1] * words[i];
			if (i > 0)
				sum += words[MAP_LEN] * words[i-1];    // x[-1] padded to zero
			if (i < MAP_LEN - 1)
				sum += words[MAP_LEN+2] * words[i+1];  // x[16] padded to zero
			c[i] = (sum < 0) ? 0 : sum;                // relu
		end
		for (int j = 0; j < POOL_LEN; j++) begin
			p = (c[2*j] > c[2*j+1]) ? c[2*j] : c[2*j+1];
			s += words[MAP_LEN+CW_LEN+j] * p;
		end
		return s;
	endfunction

	////////////////////////////////////////
	// stimulus
	task automatic stream_words(input bit gaps);
		logic [31:0] g;
		for (int k = 0; k < LOAD_WORDS; k++) begin
			@(posedge clk);
			load_valid <= 1'b1;
			load_data  <= DATA_W'(words[k]);
			if (gaps) begin
				@(posedge clk);
				load_valid <= 1'b0;  // one idle cycle at least
				rand_bits(2, g);
				repeat (g) @(posedge clk);
			end
		end
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (!done && n < RUN_CYC) begin
			@(negedge clk);
			n++;
		end
		assert (done) else begin
			$display("done did not rise within %0d cycles", RUN_CYC);
			err_cnt++;
		end
		@(negedge clk);  // let the monitor log the finish layer
	endtask

	task automatic run_net(input bit gaps);
		exp_result = model_result();
		rv_cnt     = 0;
		seen       = '0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		stream_words(gaps);
		wait_done();
		assert (rv_cnt == 1) else begin
			$display("expected one result_valid pulse in the run, saw %0d", rv_cnt);
			err_cnt++;
		end
		assert (seen == 5'b11111) else begin
			$display("Error: seen layer types = %h, expected 1f", seen);
			err_cnt++;
		end
	endtask

	task automatic drop_start();
		@(posedge clk);
		start <= 1'b0;
		repeat (2) @(negedge clk);
		assert (layer_num == 3'd0 && !done && layer_type == lt_load) else begin
			$display("Error: start low, layer_num = %h, done = %h, layer_type = %h",
				layer_num, done, layer_type);
			err_cnt++;
		end
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		if (err_cnt == mark) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d errors", tests, name, err_cnt - mark);
		end
	endtask

	////////////////////////////////////////
	// checks on every cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (layer_num <= 3'd4 && layer_type == walk_order[layer_num]) else begin
				$display("Error: layer_type = %h at layer_num = %h", layer_type, layer_num);
				err_cnt++;
			end
			if (layer_num != prev_num) begin
				assert (layer_num == prev_num + 3'd1 || layer_num == 3'd0) else begin
					$display("Error: layer_num = %h after %h", layer_num, prev_num);
					err_cnt++;
				end
			end
			seen[layer_type] = 1'b1;
			if (result_valid) begin
				rv_cnt++;
				got_result = result;
				assert (result == exp_result) else begin
					$display("Error: result = %h, expected %h", result, exp_result);
					err_cnt++;
				end
			end
		end
		prev_num = layer_num;
	end

	assert property (@(posedge clk) disable iff (!rst_n) result_valid |=> !result_valid)
		else begin
			$display("result_valid stayed high for more than one cycle");
			err_cnt++;
		end

	// done only in finish, and no more results there
	assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (layer_type == lt_finish && !result_valid))
		else begin
			$display("done was high outside the finish layer or next to a result pulse");
			err_cnt++;
		end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		int mark;
		int no_gap_result;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		mark = err_cnt;
		@(negedge clk);
		assert (!done && !result_valid && layer_num == 3'd0 && layer_type == lt_load) else begin
			$display("Error: after reset done = %h, result_valid = %h, layer_num = %h, layer_type = %h",
				done, result_valid, layer_num, layer_type);
			err_cnt++;
		end
		end_test("reset values", mark);

		mark = err_cnt;
		fill_random();
		run_net(1'b0);
		end_test("layer walk and fc result", mark);

		mark = err_cnt;
		repeat (24) begin
			@(negedge clk);
			assert (done) else begin
				$display("done fell while start was still high");
				err_cnt++;
			end
		end
		assert (rv_cnt == 1) else begin
			$display("extra result_valid pulse while done was held");
			err_cnt++;
		end
		drop_start();
		fill_random();  // new data for the second run
		run_net(1'b0);
		no_gap_result = got_result;
		drop_start();
		end_test("done hold and restart", mark);

		mark = err_cnt;
		run_net(1'b1);  // same words, gapped stream
		assert (got_result == no_gap_result) else begin
			$display("Error: result = %h, no-gap result %h", got_result, no_gap_result);
			err_cnt++;
		end
		drop_start();
		end_test("load with gaps", mark);

		mark = err_cnt;
		fill_padding();
		run_net(1'b0);
		drop_start();
		end_test("zero padding and relu", mark);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
